// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= clkgn_fstlog_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
source/clkgn_pkg.sv
source/clk_divider.sv
source/start_sequencer.sv
source/stretch_ctrl.sv
source/clkgn_fstlog.sv
sim/tb_clock_gen.sv
sim/clkgn_fstlog_sva.sv
sim/clkgn_fstlog_tb.sv

// ==== sim/clkgn_fstlog_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module clkgn_fstlog_sva
  import clkgn_pkg::*;
(
  input wire logic          ctu_clsp,
  input wire logic          rst_n,
  input wire logic          init_l,
  input wire logic          start_clk,
  input wire logic          dup_align_edge,
  input wire logic          stretch_l,
  input wire logic          jbus_mult_rst_l,
  input wire stretch_mode_e str_state
);

  // ==================================================
  // start-up order
  // ==================================================

  // release is sticky until reset
  init_sticky: assert property (@(posedge ctu_clsp) disable iff (!rst_n)
    !$fell(init_l))
    else $error("init_l fell after release");

  // release only after start seen on a duplicate edge
  init_on_edge: assert property (@(posedge ctu_clsp) disable iff (!rst_n)
    $rose(init_l) |-> $past(dup_align_edge && start_clk))
    else $error("init_l rose without a start on the alignment edge");

  // multiplier release never drops once running
  mult_rst_sticky: assert property (@(posedge ctu_clsp) disable iff (!rst_n)
    init_l |-> !$fell(jbus_mult_rst_l))
    else $error("jbus_mult_rst_l fell while init_l was high");

  // ==================================================
  // stretch
  // ==================================================

  no_early_stretch: assert property (@(posedge ctu_clsp) disable iff (!rst_n)
    !init_l |-> stretch_l)
    else $error("stretch_l low before release");

  // a pulse stretch leaves armed once the counter edge has fired
  armed_ends: assert property (@(posedge ctu_clsp) disable iff (!rst_n)
    (str_state == str_armed) && $past(str_state == str_armed) |=> (str_state == str_idle))
    else $error("stretch FSM stayed armed past the counter edge");

endmodule

`default_nettype wire

// ==== sim/clkgn_fstlog_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module clkgn_fstlog_tb
  import clkgn_pkg::*;
();

  // ==================================================
  // stimulus table
  // ==================================================

  typedef struct {
    int c_r;
    int d_r;
    int j_r;
    int s_r;
    int rep;
    int c_per;
    int c_hi;
    int d_per;
    int d_hi;
    int j_per;
    int j_hi;
  } row_t;

  localparam int n_rows      = 5;
  localparam int max_ratio   = 16;
  // rows x longest ratio x periods measured per row
  localparam int timeout_cyc = n_rows * max_ratio * 40;

  row_t tab [n_rows];

  logic     ctu_clsp;
  logic     rst_n;
  logic     reset_req;
  div_vec_t cdiv_vec;
  div_vec_t ddiv_vec;
  div_vec_t jdiv_vec;
  div_vec_t stretch_cnt_vec;
  logic     start_clk;
  logic     bypclksel;
  logic     clk_stretch_trig;
  logic     clk_stretch_cnt_val_6;
  logic     cmp_div;
  logic     dram_div;
  logic     jbus_div;
  logic     jbus_dup_div;
  logic     jbus_mult_rst_l;
  logic     jbus_alt_bypsel_l;

  // monitor state
  // phase 0 reset, 1 before start, 2 after start
  int   phase;
  logic rec_en;
  int   cyc = 0;
  logic anchor_seen = 1'b0;
  logic prev_c = 1'b0;
  logic prev_d = 1'b0;
  logic prev_j = 1'b0;
  int   rise_c[$];
  int   fall_c[$];
  int   rise_d[$];
  int   fall_d[$];
  int   rise_j[$];
  int   fall_j[$];

  tb_clock_gen tb_clock_gen_inst (
    .reset_req (reset_req),
    .ctu_clsp  (ctu_clsp),
    .rst_n     (rst_n)
  );

  clkgn_fstlog clkgn_fstlog_inst (
    .ctu_clsp              (ctu_clsp),
    .rst_n                 (rst_n),
    .cdiv_vec              (cdiv_vec),
    .ddiv_vec              (ddiv_vec),
    .jdiv_vec              (jdiv_vec),
    .stretch_cnt_vec       (stretch_cnt_vec),
    .start_clk             (start_clk),
    .bypclksel             (bypclksel),
    .clk_stretch_trig      (clk_stretch_trig),
    .clk_stretch_cnt_val_6 (clk_stretch_cnt_val_6),
    .cmp_div               (cmp_div),
    .dram_div              (dram_div),
    .jbus_div              (jbus_div),
    .jbus_dup_div          (jbus_dup_div),
    .jbus_mult_rst_l       (jbus_mult_rst_l),
    .jbus_alt_bypsel_l     (jbus_alt_bypsel_l)
  );

  bind clkgn_fstlog clkgn_fstlog_sva clkgn_fstlog_sva_inst (
    .ctu_clsp        (ctu_clsp),
    .rst_n           (rst_n),
    .init_l          (init_l),
    .start_clk       (start_clk),
    .dup_align_edge  (dup_align_edge),
    .stretch_l       (stretch_l),
    .jbus_mult_rst_l (jbus_mult_rst_l),
    .str_state       (stretch_ctrl_inst.state)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input int got, input int exp);
    fail_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", sig, got, exp));
  endtask

  // one-hot select, bit k is ratio k+2
  function automatic div_vec_t ratio_vec(input int r);
    div_vec_t v;
    v = '0;
    v[r-2] = 1'b1;
    return v;
  endfunction

  // ==================================================
  // output monitor, samples on the falling edge
  // ==================================================

  always @(negedge ctu_clsp)
  begin
    cyc++;
    assert (cyc < timeout_cyc) else fail_run("simulation ran past its cycle limit");
    if (rec_en)
    begin
      if (cmp_div && !prev_c) rise_c.push_back(cyc);
      if (!cmp_div && prev_c) fall_c.push_back(cyc);
      if (dram_div && !prev_d) rise_d.push_back(cyc);
      if (!dram_div && prev_d) fall_d.push_back(cyc);
      if (jbus_div && !prev_j) rise_j.push_back(cyc);
      if (!jbus_div && prev_j) fall_j.push_back(cyc);
    end
    if (phase == 0)
      anchor_seen = 1'b0;
    else if (phase == 1)
    begin
      assert (!cmp_div) else report_mismatch("cmp_div", int'(cmp_div), 0);
      assert (!dram_div) else report_mismatch("dram_div", int'(dram_div), 0);
      assert (!jbus_mult_rst_l)
        else report_mismatch("jbus_mult_rst_l", int'(jbus_mult_rst_l), 0);
      assert (jbus_div == jbus_dup_div)
        else report_mismatch("jbus_div", int'(jbus_div), int'(jbus_dup_div));
      assert (jbus_alt_bypsel_l == bypclksel)
        else report_mismatch("jbus_alt_bypsel_l", int'(jbus_alt_bypsel_l), int'(bypclksel));
    end
    else if (!anchor_seen)
    begin
      // first common rise of the three domains
      if (cmp_div)
      begin
        assert (dram_div && jbus_div && !prev_d && !prev_j)
          else fail_run("domain outputs did not first rise on one cycle");
        anchor_seen = 1'b1;
      end
      else
        assert (!dram_div) else report_mismatch("dram_div", int'(dram_div), 0);
      assert (!jbus_mult_rst_l)
        else report_mismatch("jbus_mult_rst_l", int'(jbus_mult_rst_l), 0);
    end
    else
    begin
      assert (jbus_mult_rst_l)
        else report_mismatch("jbus_mult_rst_l", int'(jbus_mult_rst_l), 1);
      // alternate bypass select is off once released
      assert (!jbus_alt_bypsel_l)
        else report_mismatch("jbus_alt_bypsel_l", int'(jbus_alt_bypsel_l), 0);
    end
    prev_c = cmp_div;
    prev_d = dram_div;
    prev_j = jbus_div;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge ctu_clsp);
  endtask

  task automatic clear_records();
    rise_c.delete();
    fall_c.delete();
    rise_d.delete();
    fall_d.delete();
    rise_j.delete();
    fall_j.delete();
  endtask

  // mode 0 exact, 1 one stretched period, 2 stretched while held
  task automatic check_domain(input string sig, input int rises[$], input int falls[$],
                              input int exp_per, input int exp_hi, input int mode);
    int per;
    int hi;
    int n_long;
    int j;
    n_long = 0;
    j = 0;
    assert (rises.size() >= 3) else fail_run({sig, " showed too few rising edges"});
    for (int i = 0; i + 1 < rises.size(); i++)
    begin
      per = rises[i+1] - rises[i];
      while (j < falls.size() && falls[j] < rises[i])
        j++;
      hi = (j < falls.size()) ? falls[j] - rises[i] : exp_hi;
      if (per > exp_per)
        n_long++;
      if (mode == 0)
      begin
        assert (per == exp_per) else report_mismatch({sig, " period"}, per, exp_per);
        assert (hi == exp_hi) else report_mismatch({sig, " high time"}, hi, exp_hi);
      end
      else if (mode == 1)
        assert (per == exp_per || per == exp_per + 1)
          else report_mismatch({sig, " period"}, per, exp_per);
      else
        assert (per >= exp_per) else report_mismatch({sig, " period"}, per, exp_per);
    end
    if (mode == 1)
      assert (n_long == 1) else report_mismatch({sig, " stretched periods"}, n_long, 1);
    if (mode == 2)
      assert (n_long >= 1) else fail_run({sig, " was never stretched while held"});
  endtask

  task automatic check_all(input row_t rw, input int mode);
    @(posedge ctu_clsp);
    check_domain("cmp_div", rise_c, fall_c, rw.c_per, rw.c_hi, mode);
    check_domain("dram_div", rise_d, fall_d, rw.d_per, rw.d_hi, mode);
    check_domain("jbus_div", rise_j, fall_j, rw.j_per, rw.j_hi, mode);
    clear_records();
  endtask

  // ==================================================
  // one table row
  // ==================================================

  task automatic run_row(input row_t rw);
    int row_max;
    row_max = (rw.c_r > rw.d_r) ? rw.c_r : rw.d_r;
    row_max = (rw.j_r > row_max) ? rw.j_r : row_max;
    @(negedge ctu_clsp);
    phase                 <= 0;
    rec_en                <= 1'b0;
    reset_req             <= 1'b1;
    cdiv_vec              <= ratio_vec(rw.c_r);
    ddiv_vec              <= ratio_vec(rw.d_r);
    jdiv_vec              <= ratio_vec(rw.j_r);
    stretch_cnt_vec       <= ratio_vec(rw.s_r);
    clk_stretch_cnt_val_6 <= (rw.rep != 0);
    start_clk             <= 1'b0;
    clk_stretch_trig      <= 1'b0;
    bypclksel             <= 1'($urandom_range(0, 1));
    wait_cycles(2);
    reset_req <= 1'b0;
    @(negedge ctu_clsp);
    while (!rst_n)
      @(negedge ctu_clsp);
    @(posedge ctu_clsp);
    clear_records();

    // duplicate jbus only, random start delay
    @(negedge ctu_clsp);
    phase  <= 1;
    rec_en <= 1'b1;
    wait_cycles(4 * rw.j_r + 2 + int'($urandom_range(0, 7)));
    rec_en <= 1'b0;
    @(posedge ctu_clsp);
    check_domain("jbus_div", rise_j, fall_j, rw.j_per, rw.j_hi, 0);
    clear_records();

    @(negedge ctu_clsp);
    start_clk <= 1'b1;
    phase     <= 2;
    @(posedge ctu_clsp);
    while (!anchor_seen)
      @(posedge ctu_clsp);
    @(negedge ctu_clsp);
    rec_en <= 1'b1;
    wait_cycles(4 * row_max + 2);
    rec_en <= 1'b0;
    check_all(rw, 0);

    // stretch
    @(negedge ctu_clsp);
    rec_en <= 1'b1;
    wait_cycles(2 * rw.j_r);
    clk_stretch_trig <= 1'b1;
    if (rw.rep != 0)
    begin
      wait_cycles(6 * rw.j_r);
      clk_stretch_trig <= 1'b0;
      rec_en           <= 1'b0;
      check_all(rw, 2);
      // trigger clears on the next jbus rise
      @(negedge ctu_clsp);
      wait_cycles(3 * rw.j_r + 12);
      rec_en <= 1'b1;
      wait_cycles(4 * row_max + 2);
      rec_en <= 1'b0;
      check_all(rw, 0);
    end
    else
    begin
      wait_cycles(rw.j_r + 2);
      clk_stretch_trig <= 1'b0;
      wait_cycles(4 * row_max + rw.j_r + 20);
      rec_en <= 1'b0;
      check_all(rw, 1);
    end
  endtask

  initial
  begin
    void'($urandom(32'he706_88ee));
    reset_req             <= 1'b0;
    cdiv_vec              <= '0;
    ddiv_vec              <= '0;
    jdiv_vec              <= '0;
    stretch_cnt_vec       <= '0;
    start_clk             <= 1'b0;
    bypclksel             <= 1'b0;
    clk_stretch_trig      <= 1'b0;
    clk_stretch_cnt_val_6 <= 1'b0;
    phase                 <= 0;
    rec_en                <= 1'b0;
    // c d j stretch rep, then period and high for cmp dram jbus
    tab[0] = '{2, 4, 4, 2, 0, 2, 1, 4, 2, 4, 2};
    tab[1] = '{3, 6, 6, 5, 0, 3, 1, 6, 3, 6, 3};
    tab[2] = '{4, 5, 8, 3, 1, 4, 2, 5, 2, 8, 4};
    tab[3] = '{5, 7, 16, 9, 0, 5, 2, 7, 3, 16, 8};
    tab[4] = '{3, 9, 12, 4, 1, 3, 1, 9, 4, 12, 6};
    for (int r = 0; r < n_rows; r++)
      run_row(tab[r]);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  input  wire logic reset_req,
  output logic      ctu_clsp,
  output logic      rst_n
);

  // cycles of reset still to run
  logic [2:0] low_cnt;
  // reset request seen on the rising edge
  logic       req_q;

  initial
  begin
    ctu_clsp = 1'b0;
    low_cnt  = 3'd4;
    req_q    = 1'b0;
  end

  // 40 ns period
  always #20 ctu_clsp = ~ctu_clsp;

  always @(posedge ctu_clsp)
    req_q <= reset_req;

  // reset moves on the falling edge, away from the DUT flops
  always @(negedge ctu_clsp)
  begin
    if (req_q)
      low_cnt <= 3'd4;
    else if (low_cnt != 3'd0)
      low_cnt <= low_cnt - 3'd1;
  end

  assign rst_n = (low_cnt == 3'd0);

endmodule

`default_nettype wire

// ==== source/clk_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_divider
  import clkgn_pkg::*;
(
  input  wire logic     ctu_clsp,
  input  wire logic     rst_n,
  input  wire div_vec_t div_vec,
  input  wire logic     init_l,
  input  wire logic     stretch_l,
  output logic          dom_div,
  output logic          align_edge
);

  // ==================================================
  // ratio decode
  // ==================================================

  // last phase of a period, ratio minus one
  logic [cnt_w-1:0] last_ph;
  // number of high phases, floor(ratio/2)
  logic [cnt_w-1:0] half_ph;
  // phase counter
  logic [cnt_w-1:0] cnt;
  // previous cycle was a stretch hold
  logic             held;
  logic             wrap;

  always_comb
  begin
    // default is ratio 2
    last_ph = cnt_w'(1);
    half_ph = cnt_w'(1);
    // walk down so the lowest set bit is applied last
    for (int k = div_w - 1; k >= 0; k--)
    begin
      if (div_vec[k])
      begin
        last_ph = cnt_w'(k + 1);
        half_ph = cnt_w'((k + 2) / 2);
      end
    end
  end

  // also catches a ratio lowered mid period
  assign wrap = (cnt >= last_ph);

  // ==================================================
  // phase counter and outputs
  // ==================================================

  always_ff @(posedge ctu_clsp or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt        <= '0;
      held       <= 1'b0;
      dom_div    <= 1'b0;
      align_edge <= 1'b0;
    end
    else
    begin
      // parked at phase 0 until released
      if (!init_l)
        cnt <= '0;
      // stretch holds the phase one extra cycle
      else if (stretch_l)
        cnt <= wrap ? '0 : cnt + cnt_w'(1);

      held <= init_l & ~stretch_l;

      // high phase first, then low phase
      dom_div <= init_l & (cnt < half_ph);

      // one pulse per period, even when phase 0 is held
      align_edge <= init_l & (cnt == '0) & ~held;
    end
  end

endmodule

`default_nettype wire

// ==== source/clkgn_fstlog.sv ====
`timescale 1ns/1ps
`default_nettype none

module clkgn_fstlog
  import clkgn_pkg::*;
(
  input  wire logic     ctu_clsp,
  input  wire logic     rst_n,
  input  wire div_vec_t cdiv_vec,
  input  wire div_vec_t ddiv_vec,
  input  wire div_vec_t jdiv_vec,
  input  wire div_vec_t stretch_cnt_vec,
  input  wire logic     start_clk,
  input  wire logic     bypclksel,
  input  wire logic     clk_stretch_trig,
  input  wire logic     clk_stretch_cnt_val_6,
  output logic          cmp_div,
  output logic          dram_div,
  output logic          jbus_div,
  output logic          jbus_dup_div,
  output logic          jbus_mult_rst_l,
  output logic          jbus_alt_bypsel_l
);

  // common release for the domain dividers
  logic init_l;
  // common stretch enable, active low
  logic stretch_l;
  logic jbus_main_div;
  logic dup_align_edge;

  // ==================================================
  // domain dividers
  // ==================================================

  clk_divider cmp_div_inst (
    .ctu_clsp   (ctu_clsp),
    .rst_n      (rst_n),
    .div_vec    (cdiv_vec),
    .init_l     (init_l),
    .stretch_l  (stretch_l),
    .dom_div    (cmp_div),
    .align_edge ()
  );

  clk_divider dram_div_inst (
    .ctu_clsp   (ctu_clsp),
    .rst_n      (rst_n),
    .div_vec    (ddiv_vec),
    .init_l     (init_l),
    .stretch_l  (stretch_l),
    .dom_div    (dram_div),
    .align_edge ()
  );

  clk_divider jbus_div_inst (
    .ctu_clsp   (ctu_clsp),
    .rst_n      (rst_n),
    .div_vec    (jdiv_vec),
    .init_l     (init_l),
    .stretch_l  (stretch_l),
    .dom_div    (jbus_main_div),
    .align_edge ()
  );

  // duplicate jbus divider
  // runs from reset, never stretched
  clk_divider jbus_dup_div_inst (
    .ctu_clsp   (ctu_clsp),
    .rst_n      (rst_n),
    .div_vec    (jdiv_vec),
    .init_l     (1'b1),
    .stretch_l  (1'b1),
    .dom_div    (jbus_dup_div),
    .align_edge (dup_align_edge)
  );

  // ==================================================
  // start-up and stretch control
  // ==================================================

  start_sequencer start_sequencer_inst (
    .ctu_clsp          (ctu_clsp),
    .rst_n             (rst_n),
    .start_clk         (start_clk),
    .bypclksel         (bypclksel),
    .dup_align_edge    (dup_align_edge),
    .jbus_main_div     (jbus_main_div),
    .jbus_dup_div      (jbus_dup_div),
    .init_l            (init_l),
    .jbus_div          (jbus_div),
    .jbus_mult_rst_l   (jbus_mult_rst_l),
    .jbus_alt_bypsel_l (jbus_alt_bypsel_l)
  );

  // trigger is sampled on the selected jbus output
  stretch_ctrl stretch_ctrl_inst (
    .ctu_clsp              (ctu_clsp),
    .rst_n                 (rst_n),
    .init_l                (init_l),
    .jbus_div              (jbus_div),
    .clk_stretch_trig      (clk_stretch_trig),
    .clk_stretch_cnt_val_6 (clk_stretch_cnt_val_6),
    .stretch_cnt_vec       (stretch_cnt_vec),
    .stretch_l             (stretch_l)
  );

endmodule

`default_nettype wire

// ==== source/clkgn_pkg.sv ====
`default_nettype none

package clkgn_pkg;

  // ==================================================
  // divide select
  // ==================================================

  // one bit per supported ratio
  localparam int div_w = 15;

  // one-hot divide vector
  // bit k selects ratio k+2
  // lowest set bit wins
  // all zero behaves as ratio 2
  typedef logic [div_w-1:0] div_vec_t;

  // phase counter width
  // last phase of ratio 16 is 15
  localparam int cnt_w = 4;

  // ==================================================
  // stretch timing
  // ==================================================

  // decision to stretch enable at the dividers
  localparam int str_pipe_len = 2;

  // pulse mode delay for stretch ratios above 3
  localparam int str_long_dly = 4;

  // repeat mode spacing between stretches
  localparam int str_repeat_len = 3;

  // stretch control state
  // idle waits for a trigger
  // armed runs the stretch counter for one pulse
  // repeat stretches on a fixed spacing while the trigger holds
  typedef enum logic [1:0] {
    str_idle   = 2'd0,
    str_armed  = 2'd1,
    str_repeat = 2'd2
  } stretch_mode_e;

endpackage

`default_nettype wire

// ==== source/start_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module start_sequencer
  import clkgn_pkg::*;
(
  input  wire logic ctu_clsp,
  input  wire logic rst_n,
  input  wire logic start_clk,
  input  wire logic bypclksel,
  input  wire logic dup_align_edge,
  input  wire logic jbus_main_div,
  input  wire logic jbus_dup_div,
  output logic      init_l,
  output logic      jbus_div,
  output logic      jbus_mult_rst_l,
  output logic      jbus_alt_bypsel_l
);

  // ==================================================
  // start capture
  // ==================================================

  // last start level seen on a duplicate alignment edge
  logic start_cap;
  logic start_cap_nxt;

  // start_clk only counts on the duplicate jbus edge
  // so the released dividers line up with the jbus phase
  assign start_cap_nxt = dup_align_edge ? start_clk : start_cap;

  always_ff @(posedge ctu_clsp or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start_cap <= 1'b0;
      init_l    <= 1'b0;
    end
    else
    begin
      start_cap <= start_cap_nxt;
      // sticky release, only reset clears it
      init_l    <= init_l | start_cap_nxt;
    end
  end

  // ==================================================
  // jbus output select
  // ==================================================

  // free running duplicate keeps jbus alive before release
  // main divider takes over once all domains start together
  assign jbus_div = init_l ? jbus_main_div : jbus_dup_div;

  // alternate bypass select only before release
  assign jbus_alt_bypsel_l = ~init_l & bypclksel;

  // ==================================================
  // jbus multiplier reset
  // ==================================================

  always_ff @(posedge ctu_clsp or negedge rst_n)
  begin
    if (!rst_n)
    begin
      jbus_mult_rst_l <= 1'b0;
    end
    else
    begin
      // held in reset until released
      // then set by the first main jbus high phase and kept
      jbus_mult_rst_l <= init_l & (jbus_mult_rst_l | jbus_main_div);
    end
  end

endmodule

`default_nettype wire

// ==== source/stretch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module stretch_ctrl
  import clkgn_pkg::*;
(
  input  wire logic     ctu_clsp,
  input  wire logic     rst_n,
  input  wire logic     init_l,
  input  wire logic     jbus_div,
  input  wire logic     clk_stretch_trig,
  input  wire logic     clk_stretch_cnt_val_6,
  input  wire div_vec_t stretch_cnt_vec,
  output logic          stretch_l
);

  // jbus edge detect
  logic                      jbus_q;
  logic                      jbus_rise;
  // trigger sampled on jbus rise, and its one-shot
  logic                      trig_ff;
  logic                      trig_q;
  logic                      trig_1sht;
  // mode state
  stretch_mode_e             state;
  stretch_mode_e             state_nxt;
  // stretch counter alignment pulse
  logic                      pstretch;
  logic                      pstretch_dec;
  // pulse mode delays and repeat ring
  logic                      short_dly;
  logic [str_long_dly-1:0]   long_pipe;
  logic                      pulse_dec;
  logic [str_repeat_len-1:0] rep_ring;
  logic                      rep_active;
  logic                      rep_dec_q;
  // merged decision and enable pipe
  logic                      str_dec;
  logic [str_pipe_len-1:0]   en_pipe;

  // ==================================================
  // trigger capture
  // ==================================================

  assign jbus_rise = jbus_div & ~jbus_q;
  assign trig_1sht = trig_ff & ~trig_q;

  always_ff @(posedge ctu_clsp or negedge rst_n)
  begin
    if (!rst_n)
    begin
      jbus_q  <= 1'b0;
      trig_ff <= 1'b0;
      trig_q  <= 1'b0;
    end
    else
    begin
      jbus_q <= jbus_div;
      // trigger comes from the jbus domain
      if (jbus_rise)
        trig_ff <= clk_stretch_trig;
      trig_q <= trig_ff;
    end
  end

  // ==================================================
  // mode FSM
  // ==================================================

  always_comb
  begin
    state_nxt = state;
    case (state)
      str_idle:
      begin
        if (clk_stretch_cnt_val_6 && trig_ff)
          state_nxt = str_repeat;
        else if (!clk_stretch_cnt_val_6 && trig_1sht)
          state_nxt = str_armed;
      end
      // one counted stretch, then back to idle
      str_armed:
      begin
        if (pstretch)
          state_nxt = str_idle;
      end
      str_repeat:
      begin
        if (!clk_stretch_cnt_val_6 || !trig_ff)
          state_nxt = str_idle;
      end
      default:
        state_nxt = str_idle;
    endcase
    // nothing to stretch before the dividers run
    if (!init_l)
      state_nxt = str_idle;
  end

  // stretch counter only runs while armed
  clk_divider stretch_cnt_inst (
    .ctu_clsp   (ctu_clsp),
    .rst_n      (rst_n),
    .div_vec    (stretch_cnt_vec),
    .init_l     (state == str_armed),
    .stretch_l  (1'b1),
    .dom_div    (),
    .align_edge (pstretch)
  );

  // ==================================================
  // decision timing
  // ==================================================

  // ratio 2 or 3 takes the short delay
  assign short_dly = stretch_cnt_vec[0] | stretch_cnt_vec[1] | (stretch_cnt_vec == '0);

  assign pstretch_dec = pstretch & (state == str_armed);
  // first stage is the short tap
  assign pulse_dec    = short_dly ? long_pipe[0] : long_pipe[str_long_dly-1];
  assign rep_active   = (state == str_repeat);

  // Stretching is suppressed entirely until init_l is up.
  assign str_dec = init_l & (clk_stretch_cnt_val_6 ? rep_dec_q : pulse_dec);

  always_ff @(posedge ctu_clsp or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= str_idle;
      long_pipe <= '0;
      rep_ring  <= str_repeat_len'(1);
      rep_dec_q <= 1'b0;
      en_pipe   <= '1;
    end
    else
    begin
      state     <= state_nxt;
      long_pipe <= {long_pipe[str_long_dly-2:0], pstretch_dec};
      // ring restarts whenever repeat mode is not active
      if (!rep_active || rep_ring[str_repeat_len-1])
        rep_ring <= str_repeat_len'(1);
      else
        rep_ring <= rep_ring << 1;
      rep_dec_q <= rep_active & rep_ring[str_repeat_len-1];
      // active low enable toward the dividers
      en_pipe   <= {en_pipe[str_pipe_len-2:0], ~str_dec};
    end
  end

  // common to cmp, dram and jbus
  assign stretch_l = en_pipe[str_pipe_len-1];

endmodule

`default_nettype wire
